// File: common/csr_pkg.sv
/*
 * csr package: machine CSR addresses, field positions, counter indices,
 * shared types and the CSR read-modify-write helper
 */
package csr_pkg;

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////

  localparam int NUM_PERF_CNT = 8;        // counters actually implemented

  typedef logic [11:0]             csr_addr_t;
  typedef logic [31:0]             csr_data_t;   // data word, pc or count
  typedef logic [5:0]              exc_cause_t;  // [5] irq, [4:0] code
  typedef logic [NUM_PERF_CNT-1:0] perf_mask_t;  // one bit per counter
  typedef logic [1:0]              perf_mode_t;  // [0] enable, [1] saturate
  typedef logic [3:0]              hart_core_id_t;
  typedef logic [5:0]              hart_cluster_id_t;

  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  //////////////////////////////////////////////////////////////////////
  // addresses
  //////////////////////////////////////////////////////////////////////

  // machine mode
  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MISA    = 12'h301;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;
  localparam csr_addr_t CSR_MHARTID = 12'hF14;

  // counter block, 32 slots from the base
  localparam csr_addr_t CSR_PCCR_BASE = 12'h780;
  localparam csr_addr_t CSR_PCCR_ALL  = 12'h79F;  // last slot, hits every counter
  localparam csr_addr_t CSR_PCER      = 12'h7A0;  // event enable
  localparam csr_addr_t CSR_PCMR      = 12'h7A1;  // mode

  // mstatus fields
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LSB  = 11;   // two bits wide

  localparam logic [1:0] PRIV_M = 2'b11;

  // rv32imc: mxl=1, c, i, m
  localparam csr_data_t MISA_VALUE = 32'h4000_1104;

  // counter slots
  localparam int PERF_CYCLE    = 0;
  localparam int PERF_INSTR    = 1;
  localparam int PERF_IMISS    = 2;
  localparam int PERF_LOAD     = 3;
  localparam int PERF_STORE    = 4;
  localparam int PERF_JUMP     = 5;
  localparam int PERF_BRANCH   = 6;
  localparam int PERF_BR_TAKEN = 7;

  localparam perf_mode_t PCMR_RESET = 2'b11;   // enabled, saturating

  // new register value for a csr op, old_val is the stored value
  function automatic csr_data_t csr_apply_op(input csr_data_t old_val,
                                             input csr_data_t wdata,
                                             input csr_op_e   op);
    csr_data_t res;
    case (op)
      CSR_OP_WRITE: res = wdata;
      CSR_OP_SET:   res = old_val | wdata;
      CSR_OP_CLEAR: res = old_val & ~wdata;   // drop bits set in wdata
      default:      res = old_val;
    endcase
    return res;
  endfunction

endpackage

// File: machine_csr/machine_csr_regs.sv
/*
 * machine_csr_regs: mstatus, mepc, mcause storage with read mux,
 * csr write path and trap save / mret restore
 */
`timescale 1ns/1ps

module machine_csr_regs (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  csr_pkg::hart_core_id_t    core_id_i,
  input  csr_pkg::hart_cluster_id_t cluster_id_i,
  input  csr_pkg::csr_data_t        boot_addr_i,

  input  csr_pkg::csr_addr_t        csr_addr_i,
  input  csr_pkg::csr_op_e          csr_op_i,
  input  csr_pkg::csr_data_t        csr_wdata_i,
  output csr_pkg::csr_data_t        mcsr_rdata_o,

  input  csr_pkg::csr_data_t        pc_if_i,
  input  csr_pkg::csr_data_t        pc_id_i,
  input  logic                      csr_save_if_i,
  input  logic                      csr_save_id_i,
  input  logic                      csr_save_cause_i,
  input  logic                      csr_restore_mret_i,
  input  csr_pkg::exc_cause_t       csr_cause_i,

  output logic                      m_irq_enable_o,
  output csr_pkg::csr_data_t        mepc_o
);

  // mstatus state, mpp is hardwired to machine
  logic mie_q, mie_n;
  logic mpie_q, mpie_n;

  csr_pkg::csr_data_t  mepc_q, mepc_n;
  csr_pkg::exc_cause_t mcause_q, mcause_n;

  csr_pkg::csr_data_t  csr_rdata;     // read word for the current address
  csr_pkg::csr_data_t  csr_wdata_int; // after set / clear
  logic                csr_we;

  //////////////////////////////////////////////////////////////////////
  // read mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    csr_rdata = '0;   // unknown address reads zero
    case (csr_addr_i)
      csr_pkg::CSR_MSTATUS: begin
        csr_rdata[csr_pkg::MSTATUS_MIE_BIT]       = mie_q;
        csr_rdata[csr_pkg::MSTATUS_MPIE_BIT]      = mpie_q;
        csr_rdata[csr_pkg::MSTATUS_MPP_LSB +: 2]  = csr_pkg::PRIV_M;
      end
      csr_pkg::CSR_MISA:    csr_rdata = csr_pkg::MISA_VALUE;
      csr_pkg::CSR_MTVEC:   csr_rdata = boot_addr_i;   // vector fixed at boot addr
      csr_pkg::CSR_MEPC:    csr_rdata = mepc_q;
      csr_pkg::CSR_MCAUSE:  csr_rdata = {mcause_q[5], 26'b0, mcause_q[4:0]};
      csr_pkg::CSR_MHARTID: csr_rdata = {21'b0, cluster_id_i, 1'b0, core_id_i};
      default: ;
    endcase
  end

  assign mcsr_rdata_o = csr_rdata;

  // set / clear on the stored value
  assign csr_we        = (csr_op_i != csr_pkg::CSR_OP_NONE);
  assign csr_wdata_int = csr_pkg::csr_apply_op(csr_rdata, csr_wdata_i, csr_op_i);

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mie_n    = mie_q;
    mpie_n   = mpie_q;
    mepc_n   = mepc_q;
    mcause_n = mcause_q;

    // software writes first
    if (csr_we) begin
      case (csr_addr_i)
        csr_pkg::CSR_MSTATUS: begin
          mie_n  = csr_wdata_int[csr_pkg::MSTATUS_MIE_BIT];
          mpie_n = csr_wdata_int[csr_pkg::MSTATUS_MPIE_BIT];
        end
        csr_pkg::CSR_MEPC:   mepc_n   = csr_wdata_int;
        csr_pkg::CSR_MCAUSE: mcause_n = {csr_wdata_int[31], csr_wdata_int[4:0]};
        default: ;  // misa, mtvec, mhartid read only
      endcase
    end

    // trap controller overrides
    if (csr_save_cause_i) begin
      if (csr_save_if_i) begin
        mepc_n = pc_if_i;      // fetch-stage trap
      end else if (csr_save_id_i) begin
        mepc_n = pc_id_i;      // decode-stage trap
      end
      mcause_n = csr_cause_i;
      mpie_n   = mie_q;
      mie_n    = 1'b0;         // mask irqs in the handler
    end else if (csr_restore_mret_i) begin
      mie_n  = mpie_q;
      mpie_n = 1'b1;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      mie_q    <= mie_n;
      mpie_q   <= mpie_n;
      mepc_q   <= mepc_n;
      mcause_q <= mcause_n;
    end
  end

  assign m_irq_enable_o = mie_q;
  assign mepc_o         = mepc_q;

endmodule

// File: perf_counters/perf_counters.sv
/*
 * perf_counters: eight event counters with per-counter enable,
 * global enable / saturate mode and csr access to all of it
 */
`timescale 1ns/1ps

module perf_counters (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                csr_access_i,
  input  csr_pkg::csr_addr_t  csr_addr_i,
  input  csr_pkg::csr_op_e    csr_op_i,
  input  csr_pkg::csr_data_t  csr_wdata_i,
  output logic                perf_hit_o,
  output csr_pkg::csr_data_t  perf_rdata_o,

  input  logic                if_valid_i,      // new instr from fetch
  input  logic                imiss_i,         // fetch stalled on miss
  input  logic                pc_set_i,        // pc redirect this cycle
  input  logic                jump_i,
  input  logic                branch_i,
  input  logic                branch_taken_i,
  input  logic                mem_load_i,
  input  logic                mem_store_i
);

  csr_pkg::perf_mask_t perf_event;           // raw events
  csr_pkg::perf_mask_t inc_d, inc_q;         // registered increments
  csr_pkg::perf_mask_t pcer_q, pcer_n;
  csr_pkg::perf_mode_t pcmr_q, pcmr_n;

  csr_pkg::csr_data_t  pccr_q [csr_pkg::NUM_PERF_CNT];
  csr_pkg::csr_data_t  pccr_n [csr_pkg::NUM_PERF_CNT];

  logic                is_pcer, is_pcmr, is_pccr, is_pccr_all;
  logic [4:0]          pccr_index;
  logic                csr_we;
  csr_pkg::csr_data_t  pcer_wr, pcmr_wr;     // op result, zero-extended

  //////////////////////////////////////////////////////////////////////
  // events
  //////////////////////////////////////////////////////////////////////

  assign perf_event[csr_pkg::PERF_CYCLE]    = 1'b1;
  assign perf_event[csr_pkg::PERF_INSTR]    = if_valid_i;
  assign perf_event[csr_pkg::PERF_IMISS]    = imiss_i & ~pc_set_i;  // skip redirect cycles
  assign perf_event[csr_pkg::PERF_LOAD]     = mem_load_i;
  assign perf_event[csr_pkg::PERF_STORE]    = mem_store_i;
  assign perf_event[csr_pkg::PERF_JUMP]     = jump_i;
  assign perf_event[csr_pkg::PERF_BRANCH]   = branch_i;
  assign perf_event[csr_pkg::PERF_BR_TAKEN] = branch_taken_i;

  // global enable gates every counter
  assign inc_d = pcmr_q[0] ? (perf_event & pcer_q) : '0;

  //////////////////////////////////////////////////////////////////////
  // address decode and read
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    is_pcer     = 1'b0;
    is_pcmr     = 1'b0;
    is_pccr     = 1'b0;
    is_pccr_all = 1'b0;
    pccr_index  = '0;
    if (csr_access_i) begin
      is_pcer = (csr_addr_i == csr_pkg::CSR_PCER);
      is_pcmr = (csr_addr_i == csr_pkg::CSR_PCMR);
      // 0x780..0x79f
      if (csr_addr_i[11:5] == csr_pkg::CSR_PCCR_BASE[11:5]) begin
        is_pccr     = 1'b1;
        pccr_index  = csr_addr_i[4:0];
        is_pccr_all = (csr_addr_i == csr_pkg::CSR_PCCR_ALL);
      end
    end
  end

  assign perf_hit_o = is_pcer | is_pcmr | is_pccr;

  always_comb begin
    perf_rdata_o = '0;
    if (is_pcer) perf_rdata_o[csr_pkg::NUM_PERF_CNT-1:0] = pcer_q;
    if (is_pcmr) perf_rdata_o[1:0] = pcmr_q;
    if (is_pccr && !is_pccr_all) begin
      for (int c = 0; c < csr_pkg::NUM_PERF_CNT; c++) begin
        if (pccr_index == c) perf_rdata_o = pccr_q[c];  // unused slots stay 0
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // register updates
  //////////////////////////////////////////////////////////////////////

  assign csr_we  = (csr_op_i != csr_pkg::CSR_OP_NONE);
  assign pcer_wr = csr_pkg::csr_apply_op(csr_pkg::csr_data_t'(pcer_q), csr_wdata_i, csr_op_i);
  assign pcmr_wr = csr_pkg::csr_apply_op(csr_pkg::csr_data_t'(pcmr_q), csr_wdata_i, csr_op_i);

  assign pcer_n = (is_pcer && csr_we) ? pcer_wr[csr_pkg::NUM_PERF_CNT-1:0] : pcer_q;
  assign pcmr_n = (is_pcmr && csr_we) ? pcmr_wr[1:0] : pcmr_q;

  always_comb begin
    for (int c = 0; c < csr_pkg::NUM_PERF_CNT; c++) begin
      pccr_n[c] = pccr_q[c];
      // hold at all ones when saturating
      if (inc_q[c] && ((pccr_q[c] != '1) || !pcmr_q[1])) begin
        pccr_n[c] = pccr_q[c] + 32'd1;
      end
      // csr write beats the increment
      if (is_pccr && csr_we && (is_pccr_all || (pccr_index == c))) begin
        pccr_n[c] = csr_pkg::csr_apply_op(pccr_q[c], csr_wdata_i, csr_op_i);
      end
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      pcer_q <= '0;
      pcmr_q <= csr_pkg::PCMR_RESET;
      inc_q  <= '0;
      for (int c = 0; c < csr_pkg::NUM_PERF_CNT; c++) begin
        pccr_q[c] <= '0;
      end
    end else begin
      pcer_q <= pcer_n;
      pcmr_q <= pcmr_n;
      inc_q  <= inc_d;
      for (int c = 0; c < csr_pkg::NUM_PERF_CNT; c++) begin
        pccr_q[c] <= pccr_n[c];
      end
    end
  end

endmodule

// File: verification/tb_cs_registers_tasks.svh
/*
 * testbench helpers: lfsr data, csr port access, typed compares, bounded wait
 */
`ifndef TB_CS_REGISTERS_TASKS_SVH
`define TB_CS_REGISTERS_TASKS_SVH

  // fibonacci lfsr, taps 32 22 2 1, new bit enters at bit 0
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per data bit
  task automatic draw_word(output csr_pkg::csr_data_t w);
    for (int i = 0; i < 32; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      w[i]   = lfsr_q[0];
    end
  endtask

  // expected register value after a csr op
  function automatic csr_pkg::csr_data_t op_result(input csr_pkg::csr_data_t old_val,
                                                   input csr_pkg::csr_data_t wdata,
                                                   input csr_pkg::csr_op_e   op);
    if (op == csr_pkg::CSR_OP_WRITE) return wdata;
    if (op == csr_pkg::CSR_OP_SET) return old_val | wdata;
    if (op == csr_pkg::CSR_OP_CLEAR) return old_val & ~wdata;
    return old_val;
  endfunction

  task automatic wait_cycles(input int n);
    if (n > MAX_WAIT) begin
      abort_run($sformatf("wait of %0d cycles is over the %0d cycle limit", n, MAX_WAIT));
    end else begin
      for (int i = 0; i < n; i++) begin
        @(negedge clk_i);
      end
    end
  endtask

  // address up on one falling edge, data taken on the next
  task automatic csr_read(input csr_pkg::csr_addr_t addr, output csr_pkg::csr_data_t data);
    wait_cycles(1);
    csr_access_i = 1'b1;
    csr_addr_i   = addr;
    csr_op_i     = csr_pkg::CSR_OP_NONE;
    csr_wdata_i  = '0;
    wait_cycles(1);
    data = csr_rdata_o;
  endtask

  // commits on the rising edge in between
  task automatic csr_write(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_op_e op,
                           input csr_pkg::csr_data_t data);
    wait_cycles(1);
    csr_access_i = 1'b1;
    csr_addr_i   = addr;
    csr_op_i     = op;
    csr_wdata_i  = data;
    wait_cycles(1);
    csr_access_i = 1'b0;
    csr_op_i     = csr_pkg::CSR_OP_NONE;
  endtask

  task automatic check_data(input string what, input csr_pkg::csr_data_t got,
                            input csr_pkg::csr_data_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAIL t=%0t %s: got %h, expected %h", $time, what, got, exp);
    end else begin
      $display("ok   t=%0t %s = %h", $time, what, got);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAIL t=%0t %s: got %b, expected %b", $time, what, got, exp);
    end else begin
      $display("ok   t=%0t %s = %b", $time, what, got);
    end
  endtask

`endif

// File: verification/tb_cs_registers.sv
/*
 * table driven testbench of cs_registers
 * covering the machine csrs and the performance counters
 */
`timescale 1ns/1ps

module tb_cs_registers;

  localparam time CLK_PERIOD = 20ns;
  localparam int  MAX_WAIT   = 64;                  // longest single wait in cycles
  localparam csr_pkg::csr_data_t        BOOT_ADDR  = 32'h1c00_8000;
  localparam csr_pkg::hart_core_id_t    CORE_ID    = 4'h5;
  localparam csr_pkg::hart_cluster_id_t CLUSTER_ID = 6'h2a;
  localparam csr_pkg::csr_data_t        MISA_RV32IMC =
    (32'd1 << 30) | (32'd1 << 12) | (32'd1 << 8) | (32'd1 << 2);   // mxl 1 with m, i and c

  typedef enum logic [3:0] {
    STEP_READ, STEP_IRQ, STEP_WRITE, STEP_RAND, STEP_TRAP_IF, STEP_TRAP_ID,
    STEP_MRET, STEP_EVENT, STEP_IDLE, STEP_READ_CNT
  } step_kind_e;

  typedef struct packed {
    step_kind_e         kind;
    csr_pkg::csr_addr_t addr;   // counter index for events
    csr_pkg::csr_op_e   op;
    csr_pkg::csr_data_t data;   // trap pc or cycle count for events and idle
    csr_pkg::csr_data_t exp;    // for traps also carries the mcause word
  } step_t;

  logic clk_i, rst_ni;
  logic csr_access_i;
  csr_pkg::csr_addr_t  csr_addr_i;
  csr_pkg::csr_op_e    csr_op_i;
  csr_pkg::csr_data_t  csr_wdata_i, csr_rdata_o, mepc_o, pc_if_i, pc_id_i;
  logic m_irq_enable_o;
  logic csr_save_if_i, csr_save_id_i, csr_save_cause_i, csr_restore_mret_i;
  csr_pkg::exc_cause_t csr_cause_i;
  logic if_valid_i, imiss_i, pc_set_i, jump_i, branch_i, branch_taken_i;
  logic mem_load_i, mem_store_i;

  step_t              steps[$];
  logic [31:0]        lfsr_q = 32'haf73_39d4;
  int                 n_checks = 0;
  int                 n_errors = 0;
  csr_pkg::csr_data_t mepc_model = '0;
  csr_pkg::csr_data_t mstatus_model = 32'h0000_1800;   // mpp = machine

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  cs_registers UUT (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .core_id_i (CORE_ID), .cluster_id_i (CLUSTER_ID), .boot_addr_i (BOOT_ADDR),
    .csr_access_i (csr_access_i), .csr_addr_i (csr_addr_i), .csr_op_i (csr_op_i),
    .csr_wdata_i (csr_wdata_i), .csr_rdata_o (csr_rdata_o),
    .m_irq_enable_o (m_irq_enable_o), .mepc_o (mepc_o),
    .pc_if_i (pc_if_i), .pc_id_i (pc_id_i),
    .csr_save_if_i (csr_save_if_i), .csr_save_id_i (csr_save_id_i),
    .csr_save_cause_i (csr_save_cause_i), .csr_restore_mret_i (csr_restore_mret_i),
    .csr_cause_i (csr_cause_i),
    .if_valid_i (if_valid_i), .imiss_i (imiss_i), .pc_set_i (pc_set_i), .jump_i (jump_i),
    .branch_i (branch_i), .branch_taken_i (branch_taken_i),
    .mem_load_i (mem_load_i), .mem_store_i (mem_store_i)
  );

  `include "tb_cs_registers_tasks.svh"

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  function automatic void add_step(input step_kind_e k, input csr_pkg::csr_addr_t a,
                                   input csr_pkg::csr_op_e o, input csr_pkg::csr_data_t d,
                                   input csr_pkg::csr_data_t e);
    step_t s;
    s.kind = k;
    s.addr = a;
    s.op   = o;
    s.data = d;
    s.exp  = e;
    steps.push_back(s);
  endfunction

  task automatic drive_event(input int idx, input logic val);
    case (idx)
      csr_pkg::PERF_INSTR:    if_valid_i     = val;
      csr_pkg::PERF_IMISS:    imiss_i        = val;
      csr_pkg::PERF_LOAD:     mem_load_i     = val;
      csr_pkg::PERF_STORE:    mem_store_i    = val;
      csr_pkg::PERF_JUMP:     jump_i         = val;
      csr_pkg::PERF_BRANCH:   branch_i       = val;
      csr_pkg::PERF_BR_TAKEN: branch_taken_i = val;
      default: ;   // cycle counter has no input
    endcase
  endtask

  // event high for n rising edges plus two redirect cycles for miss stalls
  task automatic pulse_event(input int idx, input int n);
    wait_cycles(1);
    drive_event(idx, 1'b1);
    wait_cycles(n);
    if (idx == csr_pkg::PERF_IMISS) begin
      pc_set_i = 1'b1;
      wait_cycles(2);
      pc_set_i = 1'b0;
    end
    drive_event(idx, 1'b0);
  endtask

  // other stage pc gets the inverse so a wrong select shows up
  task automatic raise_trap(input logic from_id, input csr_pkg::csr_data_t pc,
                            input csr_pkg::exc_cause_t cause);
    wait_cycles(1);
    csr_save_cause_i = 1'b1;
    csr_save_if_i    = !from_id;
    csr_save_id_i    = from_id;
    pc_if_i          = from_id ? ~pc : pc;
    pc_id_i          = from_id ? pc : ~pc;
    csr_cause_i      = cause;
    wait_cycles(1);
    csr_save_cause_i = 1'b0;
    csr_save_if_i    = 1'b0;
    csr_save_id_i    = 1'b0;
  endtask

  task automatic run_step(input int idx, input step_t s);
    csr_pkg::csr_data_t d;
    csr_pkg::csr_data_t rd;
    string              what;
    what = $sformatf("step %0d addr %h", idx, s.addr);
    case (s.kind)
      STEP_READ: begin
        csr_read(s.addr, rd);
        check_data(what, rd, s.exp);
        if (s.addr == csr_pkg::CSR_MEPC) check_data({what, " mepc_o"}, mepc_o, s.exp);
      end
      STEP_IRQ:   check_bit({what, " irq enable"}, m_irq_enable_o, s.exp[0]);
      STEP_WRITE: csr_write(s.addr, s.op, s.data);
      STEP_RAND: begin
        draw_word(d);
        csr_write(s.addr, s.op, d);
        csr_read(s.addr, rd);
        if (s.addr == csr_pkg::CSR_MEPC) begin
          mepc_model = op_result(mepc_model, d, s.op);
          check_data(what, rd, mepc_model);
        end else begin
          // only mie and mpie are stored and mpp stays machine
          mstatus_model = (op_result(mstatus_model, d, s.op) & 32'h0000_0088) | 32'h0000_1800;
          check_data(what, rd, mstatus_model);
          check_bit({what, " irq enable"}, m_irq_enable_o, mstatus_model[3]);
        end
      end
      STEP_TRAP_IF, STEP_TRAP_ID: begin
        raise_trap(s.kind == STEP_TRAP_ID, s.data, {s.exp[31], s.exp[4:0]});
        csr_read(csr_pkg::CSR_MEPC, rd);
        check_data({what, " mepc"}, rd, s.data);
        check_data({what, " mepc_o"}, mepc_o, s.data);
        csr_read(csr_pkg::CSR_MCAUSE, rd);
        check_data({what, " mcause"}, rd, s.exp);
        csr_read(csr_pkg::CSR_MSTATUS, rd);
        check_data({what, " mstatus"}, rd, 32'h0000_1880);   // mpie set and mie clear
        check_bit({what, " irq enable"}, m_irq_enable_o, 1'b0);
      end
      STEP_MRET: begin
        wait_cycles(1);
        csr_restore_mret_i = 1'b1;
        wait_cycles(1);
        csr_restore_mret_i = 1'b0;
        csr_read(csr_pkg::CSR_MSTATUS, rd);
        check_data({what, " mstatus"}, rd, s.exp);
        check_bit({what, " irq enable"}, m_irq_enable_o, s.exp[3]);
      end
      STEP_EVENT: pulse_event(int'(s.addr), int'(s.data));
      STEP_IDLE:  wait_cycles(int'(s.data));
      STEP_READ_CNT: begin
        for (int c = 0; c < csr_pkg::NUM_PERF_CNT; c++) begin
          csr_read(csr_pkg::CSR_PCCR_BASE + 12'(c), rd);
          check_data($sformatf("%s counter %0d", what, c), rd, s.exp);
        end
      end
      default: abort_run($sformatf("step %0d has an unknown kind", idx));
    endcase
  endtask

  task automatic build_table();
    //////////////////////////////////////////////////////////////////////
    // reset values and constants
    //////////////////////////////////////////////////////////////////////
    add_step(STEP_READ, csr_pkg::CSR_MSTATUS, csr_pkg::CSR_OP_NONE, '0, 32'h0000_1800);
    add_step(STEP_READ, csr_pkg::CSR_MTVEC, csr_pkg::CSR_OP_NONE, '0, BOOT_ADDR);
    add_step(STEP_READ, csr_pkg::CSR_MISA, csr_pkg::CSR_OP_NONE, '0, MISA_RV32IMC);
    add_step(STEP_READ, csr_pkg::CSR_MHARTID, csr_pkg::CSR_OP_NONE, '0,
             (32'(CLUSTER_ID) << 5) | 32'(CORE_ID));
    add_step(STEP_READ, csr_pkg::CSR_MEPC, csr_pkg::CSR_OP_NONE, '0, '0);
    add_step(STEP_READ, csr_pkg::CSR_PCER, csr_pkg::CSR_OP_NONE, '0, '0);
    add_step(STEP_READ, csr_pkg::CSR_PCMR, csr_pkg::CSR_OP_NONE, '0, 32'd3);
    add_step(STEP_IRQ, '0, csr_pkg::CSR_OP_NONE, '0, '0);
    // random read-modify-write checked against the model
    add_step(STEP_RAND, csr_pkg::CSR_MEPC, csr_pkg::CSR_OP_WRITE, '0, '0);
    add_step(STEP_RAND, csr_pkg::CSR_MEPC, csr_pkg::CSR_OP_SET, '0, '0);
    add_step(STEP_RAND, csr_pkg::CSR_MEPC, csr_pkg::CSR_OP_CLEAR, '0, '0);
    add_step(STEP_RAND, csr_pkg::CSR_MSTATUS, csr_pkg::CSR_OP_WRITE, '0, '0);
    add_step(STEP_RAND, csr_pkg::CSR_MSTATUS, csr_pkg::CSR_OP_SET, '0, '0);
    add_step(STEP_RAND, csr_pkg::CSR_MSTATUS, csr_pkg::CSR_OP_CLEAR, '0, '0);
    //////////////////////////////////////////////////////////////////////
    // traps with mie set first
    //////////////////////////////////////////////////////////////////////
    add_step(STEP_WRITE, csr_pkg::CSR_MSTATUS, csr_pkg::CSR_OP_WRITE, 32'h0000_0008, '0);
    add_step(STEP_TRAP_IF, '0, csr_pkg::CSR_OP_NONE, 32'h1000_0104, 32'h0000_0002);
    add_step(STEP_MRET, '0, csr_pkg::CSR_OP_NONE, '0, 32'h0000_1888);
    add_step(STEP_TRAP_ID, '0, csr_pkg::CSR_OP_NONE, 32'h2000_0a0c, 32'h8000_000b);
    // instr, imiss, store and branch events enabled
    add_step(STEP_WRITE, csr_pkg::CSR_PCER, csr_pkg::CSR_OP_WRITE, 32'h0000_0056, '0);
    add_step(STEP_EVENT, 12'(csr_pkg::PERF_INSTR), csr_pkg::CSR_OP_NONE, 32'd3, '0);
    add_step(STEP_EVENT, 12'(csr_pkg::PERF_IMISS), csr_pkg::CSR_OP_NONE, 32'd4, '0);
    add_step(STEP_EVENT, 12'(csr_pkg::PERF_LOAD), csr_pkg::CSR_OP_NONE, 32'd2, '0);
    add_step(STEP_EVENT, 12'(csr_pkg::PERF_STORE), csr_pkg::CSR_OP_NONE, 32'd5, '0);
    add_step(STEP_EVENT, 12'(csr_pkg::PERF_JUMP), csr_pkg::CSR_OP_NONE, 32'd2, '0);
    add_step(STEP_EVENT, 12'(csr_pkg::PERF_BRANCH), csr_pkg::CSR_OP_NONE, 32'd2, '0);
    add_step(STEP_EVENT, 12'(csr_pkg::PERF_BR_TAKEN), csr_pkg::CSR_OP_NONE, 32'd3, '0);
    add_step(STEP_IDLE, '0, csr_pkg::CSR_OP_NONE, 32'd3, '0);
    add_step(STEP_READ, csr_pkg::CSR_PCCR_BASE + 12'd0, csr_pkg::CSR_OP_NONE, '0, '0);
    add_step(STEP_READ, csr_pkg::CSR_PCCR_BASE + 12'd1, csr_pkg::CSR_OP_NONE, '0, 32'd3);
    add_step(STEP_READ, csr_pkg::CSR_PCCR_BASE + 12'd2, csr_pkg::CSR_OP_NONE, '0, 32'd4);
    add_step(STEP_READ, csr_pkg::CSR_PCCR_BASE + 12'd3, csr_pkg::CSR_OP_NONE, '0, '0);
    add_step(STEP_READ, csr_pkg::CSR_PCCR_BASE + 12'd4, csr_pkg::CSR_OP_NONE, '0, 32'd5);
    add_step(STEP_READ, csr_pkg::CSR_PCCR_BASE + 12'd5, csr_pkg::CSR_OP_NONE, '0, '0);
    add_step(STEP_READ, csr_pkg::CSR_PCCR_BASE + 12'd6, csr_pkg::CSR_OP_NONE, '0, 32'd2);
    add_step(STEP_READ, csr_pkg::CSR_PCCR_BASE + 12'd7, csr_pkg::CSR_OP_NONE, '0, '0);
    //////////////////////////////////////////////////////////////////////
    // load counter saturates and then wraps with mode 1
    //////////////////////////////////////////////////////////////////////
    add_step(STEP_WRITE, csr_pkg::CSR_PCER, csr_pkg::CSR_OP_WRITE, 32'h0000_0008, '0);
    add_step(STEP_WRITE, csr_pkg::CSR_PCCR_BASE + 12'd3, csr_pkg::CSR_OP_WRITE,
             32'hffff_fffe, '0);
    add_step(STEP_EVENT, 12'(csr_pkg::PERF_LOAD), csr_pkg::CSR_OP_NONE, 32'd3, '0);
    add_step(STEP_IDLE, '0, csr_pkg::CSR_OP_NONE, 32'd3, '0);
    add_step(STEP_READ, csr_pkg::CSR_PCCR_BASE + 12'd3, csr_pkg::CSR_OP_NONE, '0, '1);
    add_step(STEP_WRITE, csr_pkg::CSR_PCMR, csr_pkg::CSR_OP_WRITE, 32'd1, '0);
    add_step(STEP_WRITE, csr_pkg::CSR_PCCR_BASE + 12'd3, csr_pkg::CSR_OP_WRITE,
             32'hffff_fffe, '0);
    add_step(STEP_EVENT, 12'(csr_pkg::PERF_LOAD), csr_pkg::CSR_OP_NONE, 32'd3, '0);
    add_step(STEP_IDLE, '0, csr_pkg::CSR_OP_NONE, 32'd3, '0);
    add_step(STEP_READ, csr_pkg::CSR_PCCR_BASE + 12'd3, csr_pkg::CSR_OP_NONE, '0, 32'd1);
    // all counters at once and an unused slot reading zero
    add_step(STEP_WRITE, csr_pkg::CSR_PCER, csr_pkg::CSR_OP_WRITE, '0, '0);
    add_step(STEP_WRITE, csr_pkg::CSR_PCCR_ALL, csr_pkg::CSR_OP_WRITE, 32'hc0de_5a5a, '0);
    add_step(STEP_READ_CNT, '0, csr_pkg::CSR_OP_NONE, '0, 32'hc0de_5a5a);
    add_step(STEP_READ, csr_pkg::CSR_PCCR_BASE + 12'd20, csr_pkg::CSR_OP_NONE, '0, '0);
  endtask

  initial begin
    rst_ni             = 1'b0;
    csr_access_i       = 1'b0;
    csr_addr_i         = '0;
    csr_op_i           = csr_pkg::CSR_OP_NONE;
    csr_wdata_i        = '0;
    pc_if_i            = '0;
    pc_id_i            = '0;
    csr_save_if_i      = 1'b0;
    csr_save_id_i      = 1'b0;
    csr_save_cause_i   = 1'b0;
    csr_restore_mret_i = 1'b0;
    csr_cause_i        = '0;
    if_valid_i         = 1'b0;
    imiss_i            = 1'b0;
    pc_set_i           = 1'b0;
    jump_i             = 1'b0;
    branch_i           = 1'b0;
    branch_taken_i     = 1'b0;
    mem_load_i         = 1'b0;
    mem_store_i        = 1'b0;
    wait_cycles(5);   // reset over five rising edges
    rst_ni = 1'b1;
    build_table();
    foreach (steps[i]) begin
      run_step(i, steps[i]);
    end
    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/cs_registers.sv
/*
 * cs_registers: machine csr file of the core plus performance counters,
 * muxes read data between the two blocks
 */
`timescale 1ns/1ps

module cs_registers (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  csr_pkg::hart_core_id_t    core_id_i,
  input  csr_pkg::hart_cluster_id_t cluster_id_i,
  input  csr_pkg::csr_data_t        boot_addr_i,

  // sram-like csr port, no handshake
  input  logic                      csr_access_i,
  input  csr_pkg::csr_addr_t        csr_addr_i,
  input  csr_pkg::csr_op_e          csr_op_i,
  input  csr_pkg::csr_data_t        csr_wdata_i,
  output csr_pkg::csr_data_t        csr_rdata_o,

  output logic                      m_irq_enable_o,
  output csr_pkg::csr_data_t        mepc_o,

  // trap control from the controller
  input  csr_pkg::csr_data_t        pc_if_i,
  input  csr_pkg::csr_data_t        pc_id_i,
  input  logic                      csr_save_if_i,
  input  logic                      csr_save_id_i,
  input  logic                      csr_save_cause_i,
  input  logic                      csr_restore_mret_i,
  input  csr_pkg::exc_cause_t       csr_cause_i,

  // counter events
  input  logic                      if_valid_i,
  input  logic                      imiss_i,
  input  logic                      pc_set_i,
  input  logic                      jump_i,
  input  logic                      branch_i,
  input  logic                      branch_taken_i,
  input  logic                      mem_load_i,
  input  logic                      mem_store_i
);

  csr_pkg::csr_data_t mcsr_rdata;
  csr_pkg::csr_data_t perf_rdata;
  logic               perf_hit;

  machine_csr_regs u_machine_csr_regs (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .core_id_i          (core_id_i),
    .cluster_id_i       (cluster_id_i),
    .boot_addr_i        (boot_addr_i),
    .csr_addr_i         (csr_addr_i),
    .csr_op_i           (csr_op_i),
    .csr_wdata_i        (csr_wdata_i),
    .mcsr_rdata_o       (mcsr_rdata),
    .pc_if_i            (pc_if_i),
    .pc_id_i            (pc_id_i),
    .csr_save_if_i      (csr_save_if_i),
    .csr_save_id_i      (csr_save_id_i),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .csr_cause_i        (csr_cause_i),
    .m_irq_enable_o     (m_irq_enable_o),
    .mepc_o             (mepc_o)
  );

  perf_counters u_perf_counters (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .csr_access_i   (csr_access_i),
    .csr_addr_i     (csr_addr_i),
    .csr_op_i       (csr_op_i),
    .csr_wdata_i    (csr_wdata_i),
    .perf_hit_o     (perf_hit),
    .perf_rdata_o   (perf_rdata),
    .if_valid_i     (if_valid_i),
    .imiss_i        (imiss_i),
    .pc_set_i       (pc_set_i),
    .jump_i         (jump_i),
    .branch_i       (branch_i),
    .branch_taken_i (branch_taken_i),
    .mem_load_i     (mem_load_i),
    .mem_store_i    (mem_store_i)
  );

  // counter block wins only inside its own range
  assign csr_rdata_o = perf_hit ? perf_rdata : mcsr_rdata;

endmodule

// File: vlog.f
+incdir+verification
common/csr_pkg.sv
machine_csr/machine_csr_regs.sv
perf_counters/perf_counters.sv
verilog/cs_registers.sv
verification/tb_cs_registers.sv
